/* hdl/dcache_params.svh */
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// Processor side widths
`define DC_ADDR_W   32
`define DC_WORD_W   32

// Line holds four words
`define DC_LINE_W   128

// Address split: tag | index | word offset | byte
`define DC_OFFSET_W 2
`define DC_INDEX_W  4
`define DC_TAG_W    24

// Associativity
`define DC_WAYS     2

`endif

/* hdl/dcache_pkg.sv */
package dcache_pkg;

`include "dcache_params.svh"

    // Vector types with a meaning of their own
    typedef logic [`DC_ADDR_W-1:0]   addr_t;
    typedef logic [`DC_WORD_W-1:0]   word_t;
    typedef logic [`DC_LINE_W-1:0]   line_t;
    typedef logic [`DC_INDEX_W-1:0]  index_t;
    typedef logic [`DC_OFFSET_W-1:0] offset_t;
    typedef logic [`DC_TAG_W-1:0]    tag_t;
    typedef logic [`DC_WORD_W/8-1:0] strb_t;

    // One bit per way, one-hot for writes
    typedef logic [`DC_WAYS-1:0]     way_vec_t;

    // Controller sequence
    typedef enum logic [2:0] {
        IDLE, LOOKUP, REFILL, FILL_WR, REREAD, WR_MEM, DONE
    } dc_state_e;

endpackage

/* hdl/bram_bytewrite.sv */
`timescale 1ns/1ps

module bram_bytewrite #(
    parameter int DATA_WIDTH = 128,
    parameter int ADDR_WIDTH = 4
) (
    input  logic                    clk,
    input  logic [ADDR_WIDTH-1:0]   waddr,
    input  logic [DATA_WIDTH-1:0]   din,
    input  logic [DATA_WIDTH/8-1:0] we,
    input  logic [ADDR_WIDTH-1:0]   raddr,
    output logic [DATA_WIDTH-1:0]   dout
);

    localparam int DEPTH = 1 << ADDR_WIDTH;
    localparam int LANES = DATA_WIDTH / 8;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // Byte lanes written independently
    always_ff @(posedge clk) begin
        for (int b = 0; b < LANES; b++) begin
            if (we[b]) begin
                mem[waddr][b*8 +: 8] <= din[b*8 +: 8];
            end
        end
        // Registered read, old word on a same address collision
        dout <= mem[raddr];
    end

endmodule

/* hdl/dcache_data.sv */
`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_data
    import dcache_pkg::*;
(
    input  logic     clk,
    // Read side, both ways in parallel
    input  index_t   rd_index,
    output line_t    dout0,
    output line_t    dout1,
    // Write side
    input  index_t   wr_index,
    input  line_t    line_din,
    input  word_t    word_din,
    input  offset_t  word_offset,
    input  strb_t    byte_en,
    input  way_vec_t wr_way,
    input  logic     replace
);

    localparam int LANES = `DC_LINE_W / 8;

    logic [LANES-1:0] lane_we;
    logic [LANES-1:0] we0;
    logic [LANES-1:0] we1;
    line_t            ram_din;

    ////////////////////////////////////////////////////
    // Lane enables and write data
    ////////////////////////////////////////////////////
    always_comb begin
        if (replace) begin
            // Refill, whole line
            lane_we = '1;
            ram_din = line_din;
        end else begin
            // Store, 4 lanes per word and 32 bits per word
            lane_we = LANES'(byte_en) << {word_offset, 2'b00};
            ram_din = line_t'(word_din) << {word_offset, 5'b00000};
        end
    end

    // Only the selected way sees enables
    assign we0 = wr_way[0] ? lane_we : '0;
    assign we1 = wr_way[1] ? lane_we : '0;

    bram_bytewrite #(.DATA_WIDTH(`DC_LINE_W), .ADDR_WIDTH(`DC_INDEX_W)) way0 (
        .clk   (clk),
        .waddr (wr_index),
        .din   (ram_din),
        .we    (we0),
        .raddr (rd_index),
        .dout  (dout0)
    );

    bram_bytewrite #(.DATA_WIDTH(`DC_LINE_W), .ADDR_WIDTH(`DC_INDEX_W)) way1 (
        .clk   (clk),
        .waddr (wr_index),
        .din   (ram_din),
        .we    (we1),
        .raddr (rd_index),
        .dout  (dout1)
    );

endmodule

/* hdl/dcache_tag.sv */
`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_tag
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    // Lookup
    input  index_t   rd_index,
    input  tag_t     lookup_tag,
    output way_vec_t hit,
    output logic     lru_way,
    // Update
    input  index_t   wr_index,
    input  tag_t     wr_tag,
    input  way_vec_t tag_we,
    input  logic     lru_touch,
    input  logic     lru_way_used
);

    localparam int SETS = 1 << `DC_INDEX_W;

    tag_t            tag_mem [SETS][`DC_WAYS];
    way_vec_t        valid_mem [SETS];
    logic [SETS-1:0] lru_mem;

    // Registered read stage
    tag_t            rd_tag [`DC_WAYS];
    way_vec_t        rd_valid;
    logic            rd_lru;

    ////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (tag_we[w]) begin
                tag_mem[wr_index][w] <= wr_tag;
            end
        end
        rd_tag <= tag_mem[rd_index];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                valid_mem[s] <= '0;
            end
            lru_mem  <= '0;
            rd_valid <= '0;
            rd_lru   <= 1'b0;
        end else begin
            // A written tag makes its way valid
            valid_mem[wr_index] <= valid_mem[wr_index] | tag_we;
            // Victim becomes the way not just used
            if (lru_touch) begin
                lru_mem[wr_index] <= ~lru_way_used;
            end
            rd_valid <= valid_mem[rd_index];
            rd_lru   <= lru_mem[rd_index];
        end
    end

    ////////////////////////////////////////////////////
    // Compare
    ////////////////////////////////////////////////////
    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit[w] = rd_valid[w] && (rd_tag[w] == lookup_tag);
        end
    end

    assign lru_way = rd_lru;

endmodule

/* hdl/dcache_ctrl.sv */
`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    // APB slave
    input  logic     psel,
    input  logic     penable,
    input  logic     pwrite,
    input  addr_t    paddr,
    input  word_t    pwdata,
    input  strb_t    pstrb,
    output word_t    prdata,
    output logic     pready,
    // Backing memory
    output logic     mem_req,
    output logic     mem_we,
    output addr_t    mem_addr,
    output word_t    mem_wdata,
    output strb_t    mem_wstrb,
    input  line_t    mem_rline,
    input  logic     mem_ack,
    // Tag part
    output index_t   rd_index,
    output tag_t     lookup_tag,
    input  way_vec_t hit,
    input  logic     lru_way,
    output way_vec_t tag_we,
    output logic     lru_touch,
    output logic     lru_way_used,
    // Data part
    input  line_t    dout0,
    input  line_t    dout1,
    output index_t   wr_index,
    output way_vec_t wr_way,
    output logic     replace,
    output line_t    line_din,
    output word_t    word_din,
    output offset_t  word_offset,
    output logic [`DC_WORD_W/8-1:0] byte_en
);

    localparam int LINE_LSB = `DC_OFFSET_W + 2;

    dc_state_e state;
    dc_state_e state_nx;
    index_t    idx;
    offset_t   offset;
    logic      any_hit;
    logic      victim;
    way_vec_t  victim_vec;
    line_t     hit_line;
    line_t     fill_line;

    ////////////////////////////////////////////////////
    // Address decode and read mux
    ////////////////////////////////////////////////////
    assign lookup_tag = paddr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign idx        = paddr[LINE_LSB +: `DC_INDEX_W];
    assign offset     = paddr[2 +: `DC_OFFSET_W];
    assign rd_index   = idx;
    assign wr_index   = idx;

    assign any_hit  = |hit;
    assign hit_line = hit[1] ? dout1 : dout0;
    assign prdata   = hit_line[{offset, 5'b00000} +: `DC_WORD_W];

    // Store path, straight from APB
    assign word_din    = pwdata;
    assign word_offset = offset;
    assign byte_en     = pstrb;
    assign line_din    = fill_line;
    assign victim_vec  = way_vec_t'(1'b1) << victim;

    ////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////
    always_comb begin
        state_nx = state;
        case (state)
            // Wait for SETUP, index goes to the arrays now
            IDLE:    if (psel && !penable) state_nx = LOOKUP;
            LOOKUP:  begin
                if (pwrite) state_nx = WR_MEM;
                else if (any_hit) state_nx = IDLE;
                else state_nx = REFILL;
            end
            REFILL:  if (mem_ack) state_nx = FILL_WR;
            FILL_WR: state_nx = REREAD;
            // New line and tag land in the read stage
            REREAD:  state_nx = DONE;
            WR_MEM:  if (mem_ack) state_nx = DONE;
            DONE:    state_nx = IDLE;
            default: state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            victim <= 1'b0;
        end else begin
            state <= state_nx;
            // Hold the victim across the refill
            if (state == LOOKUP) victim <= lru_way;
        end
    end

    // Line only valid in the ack cycle
    always_ff @(posedge clk) begin
        if (state == REFILL && mem_ack) fill_line <= mem_rline;
    end

    ////////////////////////////////////////////////////
    // Array write controls
    ////////////////////////////////////////////////////
    always_comb begin
        wr_way       = '0;
        replace      = 1'b0;
        tag_we       = '0;
        lru_touch    = 1'b0;
        lru_way_used = 1'b0;
        if (state == LOOKUP && any_hit) begin
            lru_touch    = 1'b1;
            lru_way_used = hit[1];
            // Write hit updates the cached word
            if (pwrite) wr_way = hit;
        end else if (state == FILL_WR) begin
            wr_way       = victim_vec;
            replace      = 1'b1;
            tag_we       = victim_vec;
            lru_touch    = 1'b1;
            lru_way_used = victim;
        end
    end

    // Zero wait state on a read hit
    assign pready = (state == LOOKUP && !pwrite && any_hit) || (state == DONE);

    // Memory request, qualifiers stable while waiting
    assign mem_req   = (state == REFILL) || (state == WR_MEM);
    assign mem_we    = (state == WR_MEM);
    assign mem_addr  = mem_we ? {paddr[`DC_ADDR_W-1:2], 2'b00}
                              : {paddr[`DC_ADDR_W-1:LINE_LSB], LINE_LSB'(0)};
    assign mem_wdata = pwdata;
    assign mem_wstrb = pstrb;

endmodule

/* hdl/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    // APB slave
    input  logic  psel,
    input  logic  penable,
    input  logic  pwrite,
    input  addr_t paddr,
    input  word_t pwdata,
    input  strb_t pstrb,
    output word_t prdata,
    output logic  pready,
    // Refill and write-through port
    output logic  mem_req,
    output logic  mem_we,
    output addr_t mem_addr,
    output word_t mem_wdata,
    output strb_t mem_wstrb,
    input  line_t mem_rline,
    input  logic  mem_ack
);

    // Lookup
    index_t   rd_index;
    tag_t     lookup_tag;
    way_vec_t hit;
    logic     lru_way;
    line_t    dout0;
    line_t    dout1;

    // Updates from the controller
    index_t   wr_index;
    way_vec_t tag_we;
    logic     lru_touch;
    logic     lru_way_used;
    way_vec_t wr_way;
    logic     replace;
    line_t    line_din;
    word_t    word_din;
    offset_t  word_offset;
    strb_t    byte_en;

    // Refill tag is the looked up tag
    dcache_tag u_tag (.*, .wr_tag(lookup_tag));

    dcache_data u_data (.*);

    dcache_ctrl u_ctrl (.*);

endmodule

/* tb/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset released just after a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

/* tb/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model
    import dcache_pkg::*;
#(
    parameter word_t FILL_KEY = 32'h0
) (
    input  logic        clk,
    input  logic        rst_n,
    // Memory port of the cache
    input  logic        mem_req,
    input  logic        mem_we,
    input  addr_t       mem_addr,
    input  word_t       mem_wdata,
    input  strb_t       mem_wstrb,
    output line_t       mem_rline,
    output logic        mem_ack,
    // Registered lookup for the testbench
    input  addr_t       peek_addr,
    output word_t       peek_data,
    output logic [31:0] refill_count
);

    // Only words that were stored, the rest follow the fill rule
    word_t       written [addr_t];
    logic        busy;
    int unsigned wait_cnt;
    word_t       merged;

    function automatic word_t word_at(addr_t byte_addr);
        addr_t word_addr;
        word_addr = {2'b00, byte_addr[31:2]};
        if (written.exists(word_addr)) begin
            return written[word_addr];
        end
        return word_addr ^ FILL_KEY;
    endfunction

    // One seed for the whole run
    initial begin
        void'($urandom(32'hb05b));
    end

    ////////////////////////////////////////////////////
    // Request handling
    ////////////////////////////////////////////////////
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_ack      <= 1'b0;
            mem_rline    <= '0;
            busy         <= 1'b0;
            wait_cnt     <= 0;
            refill_count <= '0;
        end else begin
            // Ack lasts a single cycle
            mem_ack <= 1'b0;
            if (mem_req && !mem_ack) begin
                if (!busy) begin
                    // 1 to 6 wait cycles
                    busy     <= 1'b1;
                    wait_cnt <= 1 + ($urandom % 6);
                end else if (wait_cnt > 1) begin
                    wait_cnt <= wait_cnt - 1;
                end else begin
                    busy    <= 1'b0;
                    mem_ack <= 1'b1;
                    if (mem_we) begin
                        merged = word_at(mem_addr);
                        for (int b = 0; b < 4; b++) begin
                            if (mem_wstrb[b]) begin
                                merged[b*8 +: 8] = mem_wdata[b*8 +: 8];
                            end
                        end
                        written[{2'b00, mem_addr[31:2]}] = merged;
                    end else begin
                        // Word 0 in the low bits
                        mem_rline <= {word_at(mem_addr + 32'd12), word_at(mem_addr + 32'd8),
                                      word_at(mem_addr + 32'd4), word_at(mem_addr)};
                        refill_count <= refill_count + 1;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        peek_data <= word_at(peek_addr);
    end

endmodule

/* tb/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache
    import dcache_pkg::*;
();

    localparam int    NUM_ROWS   = 20;
    localparam int    MAX_CYCLES = NUM_ROWS * 64;
    localparam word_t FILL_KEY   = 32'h5ac3_0f96;
    localparam logic  RD         = 1'b0;
    localparam logic  WR         = 1'b1;

    // One APB transfer and what it should produce
    typedef struct packed {
        logic        write;
        addr_t       addr;
        word_t       wdata;
        strb_t       strb;
        word_t       exp_data;
        logic [31:0] exp_refills;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    addr_t       paddr;
    word_t       pwdata;
    strb_t       pstrb;
    word_t       prdata;
    logic        pready;
    logic        mem_req;
    logic        mem_we;
    addr_t       mem_addr;
    word_t       mem_wdata;
    strb_t       mem_wstrb;
    line_t       mem_rline;
    logic        mem_ack;
    addr_t       peek_addr;
    word_t       peek_data;
    logic [31:0] refill_count;

    row_t  rows [NUM_ROWS];
    int    row_count;
    word_t shadow [addr_t];
    int    error_count;
    int    check_count;
    int    cycle_count;

    tb_clkgen u_clkgen (.*);

    dcache_top u_dut (.*);

    tb_mem_model #(.FILL_KEY(FILL_KEY)) u_mem (.*);

    ////////////////////////////////////////////////////
    // Expected values from the memory rule
    ////////////////////////////////////////////////////
    function automatic word_t shadow_word(addr_t byte_addr);
        addr_t word_addr;
        word_addr = {2'b00, byte_addr[31:2]};
        if (shadow.exists(word_addr)) begin
            return shadow[word_addr];
        end
        return word_addr ^ FILL_KEY;
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t wdata, strb_t strb);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // Writes update the shadow, reads expect its current word
    function automatic void add_row(logic write, addr_t addr, word_t wdata, strb_t strb,
                                    int refills);
        word_t cur;
        cur = shadow_word(addr);
        if (write) begin
            cur = merge_bytes(cur, wdata, strb);
            shadow[{2'b00, addr[31:2]}] = cur;
        end
        rows[row_count] = '{write, addr, wdata, strb, cur, 32'(refills)};
        row_count++;
    endfunction

    function automatic void build_table();
        // Miss then hits in one line
        add_row(RD, 32'h0000_0010, '0, '0, 1);
        add_row(RD, 32'h0000_0018, '0, '0, 1);
        add_row(RD, 32'h0000_001c, '0, '0, 1);
        // Partial write hit, bytes 0 and 2
        add_row(WR, 32'h0000_0014, 32'haabb_ccdd, 4'b0101, 1);
        add_row(RD, 32'h0000_0014, '0, '0, 1);
        // Write miss goes to memory only
        add_row(WR, 32'h0000_0120, 32'h1122_3344, 4'b1111, 1);
        add_row(RD, 32'h0000_0120, '0, '0, 2);
        add_row(RD, 32'h0000_0124, '0, '0, 2);
        // Tags A, B, A, C at index 5
        add_row(RD, 32'h0000_2050, '0, '0, 3);
        add_row(RD, 32'h0000_3050, '0, '0, 4);
        add_row(RD, 32'h0000_2050, '0, '0, 4);
        add_row(RD, 32'h0000_4050, '0, '0, 5);
        // A survived, B was evicted
        add_row(RD, 32'h0000_2054, '0, '0, 5);
        add_row(RD, 32'h0000_3050, '0, '0, 6);
        add_row(RD, 32'h0000_2050, '0, '0, 6);
        // Write hit in way 1, top byte
        add_row(WR, 32'h0000_3050, 32'hfe00_0000, 4'b1000, 6);
        add_row(RD, 32'h0000_3050, '0, '0, 6);
        // Partial write miss, then refill of that line
        add_row(WR, 32'h0000_0abc, 32'h0000_beef, 4'b0011, 6);
        add_row(RD, 32'h0000_0ab0, '0, '0, 7);
        add_row(RD, 32'h0000_0abc, '0, '0, 7);
    endfunction

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////
    // APB master
    ////////////////////////////////////////////////////
    task automatic apb_transfer(input logic write, input addr_t addr, input word_t wdata,
                                input strb_t strb, output word_t rdata);
        @(posedge clk);
        #1;
        // SETUP
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        pstrb   = strb;
        @(posedge clk);
        #1;
        penable = 1'b1;
        // Mid cycle sampling
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
        end
        rdata = prdata;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    initial begin
        word_t rdata;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        pstrb       = '0;
        peek_addr   = '0;
        error_count = 0;
        check_count = 0;
        row_count   = 0;
        build_table();
        wait (rst_n === 1'b1);
        for (int i = 0; i < NUM_ROWS; i++) begin
            apb_transfer(rows[i].write, rows[i].addr, rows[i].wdata, rows[i].strb, rdata);
            if (rows[i].write) begin
                // Store must reach the backing memory
                peek_addr = rows[i].addr;
                @(posedge clk);
                @(negedge clk);
                compare($sformatf("row %0d memory word", i), peek_data, rows[i].exp_data);
            end else begin
                compare($sformatf("row %0d read data", i), rdata, rows[i].exp_data);
            end
            compare($sformatf("row %0d refill count", i), refill_count, rows[i].exp_refills);
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Run limit, 64 cycles per row
    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: no end of run within %0d cycles, %0d errors so far",
                 MAX_CYCLES, error_count);
        $display("Testbench failed");
        $finish;
    end

endmodule

/* src.f */
+incdir+hdl
hdl/dcache_pkg.sv
hdl/bram_bytewrite.sv
hdl/dcache_data.sv
hdl/dcache_tag.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
tb/tb_clkgen.sv
tb/tb_mem_model.sv
tb/tb_dcache.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_dcache -f src.f

sim_out="$(./obj_dir/Vtb_dcache)"
echo "$sim_out"

if grep -q "Testbench passed" <<< "$sim_out"; then
    exit 0
fi
exit 1
